/* dv/vga_cases.txt */
# cmd   op x0 y0 x1 y1 colour   op 0 fills a rectangle, 1 clears; bounds in cells; colour in hex
# probe px py colour            pixel position on the screen and the expected colour in hex
probe 205 10 000
probe 20 610 000
cmd 1 0 0 0 0 3a5
probe 0 0 3a5
probe 100 300 3a5
probe 199 599 3a5
cmd 0 2 3 10 20 f0c
probe 16 24 f0c
probe 15 24 3a5
probe 50 100 f0c
probe 87 167 f0c
probe 88 167 3a5
probe 16 168 3a5
cmd 0 24 74 24 74 0f0
probe 262 300 000
probe 191 592 3a5
probe 192 592 0f0
probe 199 599 0f0
probe 100 620 000

/* sim.f */
hw/vga_pkg.sv
hw/vga_timing.sv
hw/pixel_fetch.sv
hw/fill_engine.sv
hw/fb_arbiter.sv
hw/frame_buffer.sv
hw/vga_gpu.sv
dv/vga_gpu_assertions.sv
dv/tb_vga_gpu.sv

/* Bender.yml */
package:
  name: vga_gpu

sources:
  - hw/vga_pkg.sv
  - hw/vga_timing.sv
  - hw/pixel_fetch.sv
  - hw/fill_engine.sv
  - hw/fb_arbiter.sv
  - hw/frame_buffer.sv
  - hw/vga_gpu.sv
  - target: simulation
    files:
      - dv/vga_gpu_assertions.sv
      - dv/tb_vga_gpu.sv

/* dv/tb_vga_gpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_vga_gpu;
    import vga_pkg::*;

    localparam int MAX_CASES = 64;
    localparam int CLK_NS    = 40;
    localparam int FRAME     = V_TOTAL * H_TOTAL; // Clocks per frame.

    logic                   clk;
    logic                   rst;
    logic                   cmd_strobe;
    fill_op_e               cmd_op;
    logic [CELL_X_BITS-1:0] cmd_x0;
    logic [CELL_Y_BITS-1:0] cmd_y0;
    logic [CELL_X_BITS-1:0] cmd_x1;
    logic [CELL_Y_BITS-1:0] cmd_y1;
    logic [PIXEL_BITS-1:0]  cmd_color;
    logic                   busy;
    logic [COLOR_BITS-1:0]  red;
    logic [COLOR_BITS-1:0]  green;
    logic [COLOR_BITS-1:0]  blue;
    logic                   h_sync;
    logic                   v_sync;

    int          case_field [MAX_CASES][7]; // Field 0 is 0 for cmd, 1 for probe.
    int          num_cases;
    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          cases_loaded;
    longint      timeout_ns;
    logic [31:0] lfsr_state;

    int                    trk_x;
    int                    trk_y;
    bit                    h_locked;
    bit                    v_locked;
    logic                  smp_hs;
    logic                  smp_vs;
    logic                  smp_busy;
    logic [PIXEL_BITS-1:0] smp_color;

    vga_gpu dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_strobe (cmd_strobe),
        .cmd_op     (cmd_op),
        .cmd_x0     (cmd_x0),
        .cmd_y0     (cmd_y0),
        .cmd_x1     (cmd_x1),
        .cmd_y1     (cmd_y1),
        .cmd_color  (cmd_color),
        .busy       (busy),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .h_sync     (h_sync),
        .v_sync     (v_sync)
    );

    always #20 clk = ~clk;

    // ==================================================
    // Raster tracking from the output sync edges
    // ==================================================

    always @(negedge clk) begin
        if (rst) begin
            h_locked = 1'b0;
            v_locked = 1'b0;
            trk_x    = 0;
            trk_y    = 0;
        end else begin
            if (smp_hs === 1'b1 && h_sync === 1'b0) begin
                trk_x    = H_VIS + H_FRONT; // First clock of the sync pulse.
                h_locked = 1'b1;
            end else if (trk_x == H_TOTAL - 1) begin
                trk_x = 0;
                trk_y = (trk_y == V_TOTAL - 1) ? 0 : trk_y + 1;
            end else begin
                trk_x = trk_x + 1;
            end
            if (smp_vs === 1'b1 && v_sync === 1'b0) begin
                trk_y    = V_VIS + V_FRONT;
                v_locked = h_locked;
            end
        end
        smp_hs    = h_sync;
        smp_vs    = v_sync;
        smp_busy  = busy;
        smp_color = {red, green, blue};
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    function automatic logic sync_of(input bit vert);
        return vert ? smp_vs : smp_hs;
    endfunction

    // ==================================================
    // Compare tasks and reporting
    // ==================================================

    task automatic check_color(input string name, input logic [PIXEL_BITS-1:0] exp,
                               input logic [PIXEL_BITS-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s expected %03h, got %03h", $time, name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %0d %s: FAILED", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    n;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        int    f;
        string line;
        string kind;
        num_cases = 0;
        fd = $fopen("dv/vga_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dv/vga_cases.txt");
            return;
        end
        while (!$feof(fd) && num_cases < MAX_CASES) begin
            line = "";
            n = $fgets(line, fd);
            kind = "";
            n = $sscanf(line, "%s", kind);
            if (n < 1 || kind.len() == 0 || kind[0] == 8'h23) begin
                continue; // Blank line or comment.
            end
            if (kind == "cmd") begin
                n = $sscanf(line, "%s %d %d %d %d %d %h", kind, a, b, c, d, e, f);
                case_field[num_cases] = '{0, a, b, c, d, e, f};
                n = n - 7;
            end else begin
                n = $sscanf(line, "%s %d %d %h", kind, a, b, c);
                case_field[num_cases] = '{1, a, b, c, 0, 0, 0};
                n = (kind == "probe") ? n - 4 : -1;
            end
            if (n != 0) begin
                errors++;
                $display("malformed case line: %s", line);
            end else begin
                num_cases++;
            end
        end
        $fclose(fd);
    endtask

    // ==================================================
    // Test steps
    // ==================================================

    task automatic measure_sync(input bit vert, output int low_cycles, output int period);
        int n;
        n = 0;
        while (sync_of(vert) !== 1'b1) begin
            @(posedge clk);
        end
        while (sync_of(vert) !== 1'b0) begin
            @(posedge clk);
        end
        while (sync_of(vert) === 1'b0) begin
            @(posedge clk);
            n++;
        end
        low_cycles = n;
        while (sync_of(vert) === 1'b1) begin
            @(posedge clk);
            n++;
        end
        period = n;
    endtask

    task automatic run_command(input int idx);
        fill_op_e op;
        int       cells;
        int       offset;
        int       waited;
        op    = fill_op_e'(case_field[idx][1]);
        cells = (op == OP_CLEAR) ? FB_DEPTH :
                (case_field[idx][4] - case_field[idx][2] + 1) *
                (case_field[idx][5] - case_field[idx][3] + 1);
        @(posedge clk);
        cmd_strobe <= 1'b1;
        cmd_op     <= op;
        cmd_x0     <= CELL_X_BITS'(case_field[idx][2]);
        cmd_y0     <= CELL_Y_BITS'(case_field[idx][3]);
        cmd_x1     <= CELL_X_BITS'(case_field[idx][4]);
        cmd_y1     <= CELL_Y_BITS'(case_field[idx][5]);
        cmd_color  <= PIXEL_BITS'(case_field[idx][6]);
        @(posedge clk);
        cmd_strobe <= 1'b0;
        @(posedge clk);
        check_level("busy", 1'b1, smp_busy);
        // At most one cell per clock, so a long command is surely still running.
        if (cells >= 40) begin
            offset = 1 + random_bits(5);
            repeat (offset) @(posedge clk);
            cmd_strobe <= 1'b1;
            cmd_op     <= OP_CLEAR;
            cmd_color  <= ~PIXEL_BITS'(case_field[idx][6]);
            @(posedge clk);
            cmd_strobe <= 1'b0;
        end
        waited = 0;
        while (smp_busy !== 1'b0 && waited < 2 * FRAME) begin
            @(posedge clk);
            waited++;
        end
        if (smp_busy !== 1'b0) begin
            errors++;
            $display("busy still high %0d clocks into command %0d", waited, idx);
        end
    endtask

    task automatic run_probe(input int px, input int py, input logic [PIXEL_BITS-1:0] exp);
        @(posedge clk);
        while (!(v_locked && trk_x == px && trk_y == py)) begin
            @(posedge clk);
        end
        check_color($sformatf("rgb at %0d,%0d", px, py), exp, smp_color);
    endtask

    initial begin
        int errs_before;
        int low_cycles;
        int period;
        clk          = 1'b0;
        rst          = 1'b1;
        cmd_strobe   = 1'b0;
        cmd_op       = OP_FILL_RECT;
        cmd_x0       = '0;
        cmd_y0       = '0;
        cmd_x1       = '0;
        cmd_y1       = '0;
        cmd_color    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        lfsr_state   = 32'h46ea;
        load_cases();
        timeout_ns   = longint'(num_cases + 4) * FRAME * CLK_NS;
        cases_loaded = 1'b1;

        repeat (9) @(posedge clk);
        @(negedge clk);
        errs_before = errors;
        check_level("h_sync", 1'b1, h_sync);
        check_level("v_sync", 1'b1, v_sync);
        check_color("rgb", '0, {red, green, blue});
        check_level("busy", 1'b0, busy);
        check_level("fill state idle", 1'b1, dut.u_fill.state == FILL_IDLE);
        finish_test("reset values", errs_before);
        @(posedge clk);
        rst <= 1'b0; // Ten clocks of reset.

        errs_before = errors;
        measure_sync(1'b0, low_cycles, period);
        check_count("h_sync low clocks", H_SYNC, low_cycles);
        check_count("h_sync period", H_TOTAL, period);
        measure_sync(1'b1, low_cycles, period);
        check_count("v_sync low clocks", V_SYNC * H_TOTAL, low_cycles);
        check_count("v_sync period", V_TOTAL * H_TOTAL, period);
        finish_test("sync timing", errs_before);

        for (int i = 0; i < num_cases; i++) begin
            errs_before = errors;
            if (case_field[i][0] == 0) begin
                run_command(i);
                finish_test($sformatf("command line %0d", i), errs_before);
            end else begin
                run_probe(case_field[i][1], case_field[i][2], PIXEL_BITS'(case_field[i][3]));
                finish_test($sformatf("probe %0d,%0d", case_field[i][1], case_field[i][2]),
                            errs_before);
            end
        end

        errors = errors + dut.u_assertions.failures;
        $display("%0d tests run, %0d passed, %0d with errors, %0d errors in total",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (cases_loaded);
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the run did not finish", timeout_ns);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/vga_gpu_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_gpu_assertions (
    input logic                           clk,
    input logic                           rst,
    input logic                           cmd_strobe,
    input logic                           busy,
    input logic                           fetch_req,
    input logic                           ram_we,
    input logic                           h_sync,
    input logic [vga_pkg::COLOR_BITS-1:0] red,
    input logic [vga_pkg::COLOR_BITS-1:0] green,
    input logic [vga_pkg::COLOR_BITS-1:0] blue,
    input vga_pkg::fill_state_e           state
);
    import vga_pkg::*;

    int failures = 0;

    // A strobe outside a running command is taken and busy follows one clock later.
    busy_after_accept: assert property (@(posedge clk) disable iff (rst)
        (cmd_strobe && state != FILL_RUN) |=> busy)
    else begin
        failures++;
        $error("busy did not rise after an accepted command strobe");
    end

    // The display read always owns the RAM port.
    no_write_on_fetch: assert property (@(posedge clk) disable iff (rst)
        fetch_req |-> !ram_we)
    else begin
        failures++;
        $error("frame buffer written during a fetch read");
    end

    dark_in_hsync: assert property (@(posedge clk) disable iff (rst)
        !h_sync |-> (red == '0 && green == '0 && blue == '0))
    else begin
        failures++;
        $error("colour is not zero during horizontal sync");
    end

endmodule

bind vga_gpu vga_gpu_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .cmd_strobe (cmd_strobe),
    .busy       (busy),
    .fetch_req  (fetch_req),
    .ram_we     (ram_we),
    .h_sync     (h_sync),
    .red        (red),
    .green      (green),
    .blue       (blue),
    .state      (u_fill.state)
);

`default_nettype wire

/* hw/vga_gpu.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_gpu (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cmd_strobe,
    input  vga_pkg::fill_op_e              cmd_op,
    input  logic [vga_pkg::CELL_X_BITS-1:0] cmd_x0,
    input  logic [vga_pkg::CELL_Y_BITS-1:0] cmd_y0,
    input  logic [vga_pkg::CELL_X_BITS-1:0] cmd_x1,
    input  logic [vga_pkg::CELL_Y_BITS-1:0] cmd_y1,
    input  logic [vga_pkg::PIXEL_BITS-1:0]  cmd_color,
    output logic                           busy,
    output logic [vga_pkg::COLOR_BITS-1:0]  red,
    output logic [vga_pkg::COLOR_BITS-1:0]  green,
    output logic [vga_pkg::COLOR_BITS-1:0]  blue,
    output logic                           h_sync,
    output logic                           v_sync
);
    import vga_pkg::*;

    logic [H_BITS-1:0]       h_count;
    logic [V_BITS-1:0]       v_count;
    logic                    h_sync_raw;
    logic                    v_sync_raw;
    logic                    visible;
    logic                    fetch_req;
    logic [FB_ADDR_BITS-1:0] fetch_addr;
    logic                    fill_req;
    logic                    fill_grant;
    logic [FB_ADDR_BITS-1:0] fill_addr;
    logic [PIXEL_BITS-1:0]   fill_data;
    logic [FB_ADDR_BITS-1:0] ram_addr;
    logic                    ram_we;
    logic [PIXEL_BITS-1:0]   ram_wdata;
    logic [PIXEL_BITS-1:0]   rdata;

    vga_timing u_timing (
        .clk        (clk),
        .rst        (rst),
        .h_count    (h_count),
        .v_count    (v_count),
        .h_sync_raw (h_sync_raw),
        .v_sync_raw (v_sync_raw),
        .visible    (visible)
    );

    pixel_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .h_count    (h_count),
        .v_count    (v_count),
        .h_sync_raw (h_sync_raw),
        .v_sync_raw (v_sync_raw),
        .visible    (visible),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .rdata      (rdata),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .h_sync     (h_sync),
        .v_sync     (v_sync)
    );

    fill_engine u_fill (
        .clk        (clk),
        .rst        (rst),
        .cmd_strobe (cmd_strobe),
        .cmd_op     (cmd_op),
        .cmd_x0     (cmd_x0),
        .cmd_x1     (cmd_x1),
        .cmd_y0     (cmd_y0),
        .cmd_y1     (cmd_y1),
        .cmd_color  (cmd_color),
        .busy       (busy),
        .fill_req   (fill_req),
        .fill_grant (fill_grant),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data)
    );

    fb_arbiter u_arb (
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fill_req   (fill_req),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data),
        .fill_grant (fill_grant),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_wdata  (ram_wdata)
    );

    frame_buffer u_fb (
        .clk       (clk),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_wdata (ram_wdata),
        .rdata     (rdata)
    );

endmodule

`default_nettype wire

/* hw/frame_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_buffer (
    input  logic                            clk,
    input  logic [vga_pkg::FB_ADDR_BITS-1:0] ram_addr,
    input  logic                            ram_we,
    input  logic [vga_pkg::PIXEL_BITS-1:0]   ram_wdata,
    output logic [vga_pkg::PIXEL_BITS-1:0]   rdata
);
    import vga_pkg::*;

    logic [PIXEL_BITS-1:0] mem [FB_DEPTH];

    // Read returns the old word when the same address is written.
    always_ff @(posedge clk) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
        rdata <= mem[ram_addr];
    end

endmodule

`default_nettype wire

/* hw/fb_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module fb_arbiter (
    input  logic                            fetch_req,
    input  logic [vga_pkg::FB_ADDR_BITS-1:0] fetch_addr,
    input  logic                            fill_req,
    input  logic [vga_pkg::FB_ADDR_BITS-1:0] fill_addr,
    input  logic [vga_pkg::PIXEL_BITS-1:0]   fill_data,
    output logic                            fill_grant,
    output logic [vga_pkg::FB_ADDR_BITS-1:0] ram_addr,
    output logic                            ram_we,
    output logic [vga_pkg::PIXEL_BITS-1:0]   ram_wdata
);

    // ==================================================
    // Fixed priority, fetch over fill
    // ==================================================

    // The display never waits. Fill only gets the port in blanking.
    assign fill_grant = fill_req && !fetch_req;

    always_comb begin
        if (fill_grant) begin
            ram_addr = fill_addr;
            ram_we   = 1'b1;
        end else begin
            ram_addr = fetch_addr; // Fetch owns the port by default.
            ram_we   = 1'b0;
        end
    end

    assign ram_wdata = fill_data;

endmodule

`default_nettype wire

/* hw/fill_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module fill_engine (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cmd_strobe,
    input  vga_pkg::fill_op_e               cmd_op,
    input  logic [vga_pkg::CELL_X_BITS-1:0]  cmd_x0,
    input  logic [vga_pkg::CELL_X_BITS-1:0]  cmd_x1,
    input  logic [vga_pkg::CELL_Y_BITS-1:0]  cmd_y0,
    input  logic [vga_pkg::CELL_Y_BITS-1:0]  cmd_y1,
    input  logic [vga_pkg::PIXEL_BITS-1:0]   cmd_color,
    output logic                            busy,
    output logic                            fill_req,
    input  logic                            fill_grant,
    output logic [vga_pkg::FB_ADDR_BITS-1:0] fill_addr,
    output logic [vga_pkg::PIXEL_BITS-1:0]   fill_data
);
    import vga_pkg::*;

    fill_state_e            state;
    logic                   accept;
    logic                   is_clear;
    logic                   last_col;
    logic                   last_row;
    logic [CELL_X_BITS-1:0] x0_q;
    logic [CELL_X_BITS-1:0] x1_q;
    logic [CELL_Y_BITS-1:0] y1_q;
    logic [CELL_X_BITS-1:0] cur_x;
    logic [CELL_Y_BITS-1:0] cur_y;
    logic [PIXEL_BITS-1:0]  color_q;

    assign busy     = (state == FILL_RUN);
    assign accept   = cmd_strobe && !busy; // Strobes while busy are dropped.
    assign is_clear = (cmd_op == OP_CLEAR);
    assign last_col = (cur_x == x1_q);
    assign last_row = (cur_y == y1_q);

    // ==================================================
    // Control
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILL_IDLE;
        end else begin
            case (state)
                FILL_IDLE, FILL_DONE: state <= accept ? FILL_RUN : FILL_IDLE;
                FILL_RUN: begin
                    if (fill_grant && last_col && last_row) begin
                        state <= FILL_DONE; // Final cell written.
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

    // ==================================================
    // Command latch and cell walk
    // ==================================================

    always_ff @(posedge clk) begin
        if (accept) begin
            x0_q    <= is_clear ? '0 : cmd_x0;
            x1_q    <= is_clear ? CELL_X_BITS'(CELLS_X - 1) : cmd_x1;
            y1_q    <= is_clear ? CELL_Y_BITS'(CELLS_Y - 1) : cmd_y1;
            cur_x   <= is_clear ? '0 : cmd_x0;
            cur_y   <= is_clear ? '0 : cmd_y0;
            color_q <= cmd_color;
        end else if (fill_grant) begin
            if (last_col) begin
                cur_x <= x0_q; // Back to the left edge of the next row.
                cur_y <= cur_y + 1'b1;
            end else begin
                cur_x <= cur_x + 1'b1;
            end
        end
    end

    assign fill_req  = (state == FILL_RUN);
    assign fill_addr = FB_ADDR_BITS'(cur_y * CELLS_X + cur_x);
    assign fill_data = color_q;

endmodule

`default_nettype wire

/* hw/pixel_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_fetch (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [vga_pkg::H_BITS-1:0]       h_count,
    input  logic [vga_pkg::V_BITS-1:0]       v_count,
    input  logic                            h_sync_raw,
    input  logic                            v_sync_raw,
    input  logic                            visible,
    output logic                            fetch_req,
    output logic [vga_pkg::FB_ADDR_BITS-1:0] fetch_addr,
    input  logic [vga_pkg::PIXEL_BITS-1:0]   rdata,
    output logic [vga_pkg::COLOR_BITS-1:0]   red,
    output logic [vga_pkg::COLOR_BITS-1:0]   green,
    output logic [vga_pkg::COLOR_BITS-1:0]   blue,
    output logic                            h_sync,
    output logic                            v_sync
);
    import vga_pkg::*;

    logic [H_BITS-CELL_SHIFT-1:0] cell_col;
    logic [V_BITS-CELL_SHIFT-1:0] cell_row;
    logic                         h_sync_d1;
    logic                         v_sync_d1;
    logic                         visible_d1;

    // ==================================================
    // Cell read request
    // ==================================================

    assign cell_col = h_count[H_BITS-1:CELL_SHIFT];
    assign cell_row = v_count[V_BITS-1:CELL_SHIFT];

    assign fetch_req  = visible;
    assign fetch_addr = visible ? FB_ADDR_BITS'(cell_row * CELLS_X + cell_col) : '0; // Parked at 0.

    // ==================================================
    // Output alignment
    // ==================================================

    // First stage runs in step with the RAM read.
    always_ff @(posedge clk) begin
        if (rst) begin
            h_sync_d1  <= 1'b1;
            v_sync_d1  <= 1'b1;
            visible_d1 <= 1'b0;
        end else begin
            h_sync_d1  <= h_sync_raw;
            v_sync_d1  <= v_sync_raw;
            visible_d1 <= visible;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h_sync <= 1'b1;
            v_sync <= 1'b1;
            red    <= '0;
            green  <= '0;
            blue   <= '0;
        end else begin
            h_sync <= h_sync_d1;
            v_sync <= v_sync_d1;
            red    <= visible_d1 ? rdata[PIXEL_BITS-1 -: COLOR_BITS] : '0;
            green  <= visible_d1 ? rdata[2*COLOR_BITS-1 -: COLOR_BITS] : '0;
            blue   <= visible_d1 ? rdata[COLOR_BITS-1:0] : '0; // Blanked outside the screen.
        end
    end

endmodule

`default_nettype wire

/* hw/vga_timing.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_timing (
    input  logic                      clk,
    input  logic                      rst,
    output logic [vga_pkg::H_BITS-1:0] h_count,
    output logic [vga_pkg::V_BITS-1:0] v_count,
    output logic                      h_sync_raw,
    output logic                      v_sync_raw,
    output logic                      visible
);
    import vga_pkg::*;

    logic [H_BITS-1:0] h_cnt;
    logic [V_BITS-1:0] v_cnt;
    logic              h_wrap;
    logic              v_wrap;
    logic              h_in_sync;
    logic              v_in_sync;

    // ==================================================
    // Counters
    // ==================================================

    assign h_wrap = (h_cnt == H_BITS'(H_TOTAL - 1)); // Last clock of the line.
    assign v_wrap = (v_cnt == V_BITS'(V_TOTAL - 1)); // Last line of the frame.

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v_cnt <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    // ==================================================
    // Decode
    // ==================================================

    assign h_in_sync = (h_cnt >= H_VIS + H_FRONT) && (h_cnt < H_VIS + H_FRONT + H_SYNC);
    assign v_in_sync = (v_cnt >= V_VIS + V_FRONT) && (v_cnt < V_VIS + V_FRONT + V_SYNC);

    assign h_count    = h_cnt;
    assign v_count    = v_cnt;
    assign h_sync_raw = !h_in_sync; // Both syncs are active low.
    assign v_sync_raw = !v_in_sync;
    assign visible    = (h_cnt < H_VIS) && (v_cnt < V_VIS);

endmodule

`default_nettype wire

/* hw/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    // ==================================================
    // Raster timing
    // ==================================================

    localparam int H_VIS   = 200;
    localparam int H_FRONT = 10;
    localparam int H_SYNC  = 32;
    localparam int H_BACK  = 22;
    localparam int H_TOTAL = H_VIS + H_FRONT + H_SYNC + H_BACK; // 264 clocks per line.

    localparam int V_VIS   = 600;
    localparam int V_FRONT = 1;
    localparam int V_SYNC  = 4;
    localparam int V_BACK  = 23;
    localparam int V_TOTAL = V_VIS + V_FRONT + V_SYNC + V_BACK; // 628 lines per frame.

    localparam int H_BITS = 9;  // Holds 0 to H_TOTAL-1.
    localparam int V_BITS = 10; // Holds 0 to V_TOTAL-1.

    // ==================================================
    // Frame buffer geometry
    // ==================================================

    localparam int CELL_SHIFT   = 3; // Cells are 8 x 8 pixels.
    localparam int CELLS_X      = H_VIS >> CELL_SHIFT;
    localparam int CELLS_Y      = V_VIS >> CELL_SHIFT;
    localparam int CELL_X_BITS  = 5;
    localparam int CELL_Y_BITS  = 7;
    localparam int FB_DEPTH     = CELLS_X * CELLS_Y; // 1875 words, row major.
    localparam int FB_ADDR_BITS = 11;

    localparam int COLOR_BITS = 4;
    localparam int PIXEL_BITS = 3 * COLOR_BITS; // Red on top, then green, then blue.

    // ==================================================
    // Fill engine types
    // ==================================================

    typedef enum logic {
        OP_FILL_RECT = 1'b0,
        OP_CLEAR     = 1'b1
    } fill_op_e;

    typedef enum logic [1:0] {
        FILL_IDLE = 2'd0,
        FILL_RUN  = 2'd1,
        FILL_DONE = 2'd2
    } fill_state_e;

endpackage

`default_nettype wire
